//--- coreDefs.sv
package coreDefs;

    ////////////////////////////////////////
    // Basic words and indices
    ////////////////////////////////////////
    typedef logic [31:0] dataT;
    typedef logic [3:0]  regIdxT;

    // Enough for up to 16 ROB entries
    localparam int RobTagBits = 4;
    typedef logic [RobTagBits-1:0] robTagT;

    typedef enum logic [2:0] {
        OpAdd,
        OpSub,
        OpAnd,
        OpOrr,
        OpEor,
        OpMov,
        OpMul
    } opcodeT;

    typedef enum logic [1:0] {
        ShLsl,
        ShLsr,
        ShAsr,
        ShRor
    } shiftT;

    ////////////////////////////////////////
    // Micro-op and result buses
    ////////////////////////////////////////
    typedef struct packed {
        opcodeT      opcode;
        regIdxT      dest;
        regIdxT      srcA;
        regIdxT      srcB;
        logic        useImm;
        logic [11:0] imm;
        shiftT       shiftType;
        logic [4:0]  shamt;
    } microOpT;

    // Execution unit to reorder buffer
    typedef struct packed {
        logic   valid;
        robTagT tag;
        dataT   value;
    } completionT;

    typedef struct packed {
        logic   valid;
        regIdxT dest;
        dataT   value;
    } commitT;

endpackage

//--- issueGate.sv
module issueGate (
    input  logic              CLK,
    input  logic              arstN,
    input  logic              opValid,
    input  coreDefs::microOpT op,
    input  logic              robFull,
    input  logic              mulBusy,
    input  coreDefs::commitT  commit,
    output logic              issueStall,
    output logic              issue
);

    // One bit per architectural register with a result in flight
    logic [15:0] pending;
    logic [15:0] setMask;
    logic [15:0] clrMask;
    logic        hazardA;
    logic        hazardB;
    logic        hazardDest;
    logic        mulConflict;

    assign hazardA    = pending[op.srcA];
    assign hazardB    = pending[op.srcB] && !op.useImm;
    assign hazardDest = pending[op.dest];

    // Only one multiply can be in the sequencer at a time
    assign mulConflict = (op.opcode == coreDefs::OpMul) && mulBusy;

    assign issueStall = robFull || mulConflict || hazardA || hazardB || hazardDest;
    assign issue      = opValid && !issueStall;

    always_comb begin
        setMask = '0;
        clrMask = '0;
        if (issue) begin
            setMask[op.dest] = 1'b1;
        end
        if (commit.valid) begin
            clrMask[commit.dest] = 1'b1;
        end
    end

    // Set after clear, so a new mark survives a commit to the same register
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clrMask) | setMask;
        end
    end

endmodule

//--- robPointers.sv
module robPointers #(
    parameter int RobDepth = 4
) (
    input  logic             CLK,
    input  logic             arstN,
    input  logic             alloc,
    input  logic             retire,
    output coreDefs::robTagT head,
    output coreDefs::robTagT tail,
    output logic             full,
    output logic             empty
);

    localparam int CountBits = $clog2(RobDepth + 1);
    localparam coreDefs::robTagT LastTag = coreDefs::robTagT'(RobDepth - 1);

    logic [CountBits-1:0] count;

    assign full  = (count == CountBits'(RobDepth));
    assign empty = (count == '0);

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc) begin
                tail <= (tail == LastTag) ? '0 : tail + 1'b1;
            end
            if (retire) begin
                head <= (head == LastTag) ? '0 : head + 1'b1;
            end
            // Alloc and retire together leave the count alone
            case ({alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- reorderBuffer.sv
module reorderBuffer #(
    parameter int RobDepth = 4
) (
    input  logic                 CLK,
    input  logic                 arstN,
    input  logic                 issue,
    input  coreDefs::regIdxT     issueDest,
    input  coreDefs::completionT aluDone,
    input  coreDefs::completionT mulDone,
    output coreDefs::robTagT     tail,
    output logic                 full,
    output coreDefs::commitT     commit
);

    localparam int IdxBits = $clog2(RobDepth);

    coreDefs::regIdxT    destQ  [RobDepth];
    coreDefs::dataT      valueQ [RobDepth];
    logic [RobDepth-1:0] doneQ;
    coreDefs::robTagT    head;
    logic                empty;
    logic                retire;

    robPointers #(
        .RobDepth (RobDepth)
    ) robPointers_i (
        .CLK    (CLK),
        .arstN  (arstN),
        .alloc  (issue),
        .retire (retire),
        .head   (head),
        .tail   (tail),
        .full   (full),
        .empty  (empty)
    );

    // In-order retire of the oldest entry
    assign retire = doneQ[head[IdxBits-1:0]] && !empty;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            doneQ <= '0;
        end else begin
            if (issue) begin
                doneQ[tail[IdxBits-1:0]] <= 1'b0;
            end
            if (aluDone.valid) begin
                doneQ[aluDone.tag[IdxBits-1:0]] <= 1'b1;
            end
            if (mulDone.valid) begin
                doneQ[mulDone.tag[IdxBits-1:0]] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Entry payload, written by tag
    ////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (issue) begin
            destQ[tail[IdxBits-1:0]] <= issueDest;
        end
        if (aluDone.valid) begin
            valueQ[aluDone.tag[IdxBits-1:0]] <= aluDone.value;
        end
        if (mulDone.valid) begin
            valueQ[mulDone.tag[IdxBits-1:0]] <= mulDone.value;
        end
    end

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            commit <= '0;
        end else begin
            commit.valid <= retire;
            commit.dest  <= destQ[head[IdxBits-1:0]];
            commit.value <= valueQ[head[IdxBits-1:0]];
        end
    end

endmodule

//--- aluPipe.sv
module aluPipe (
    input  logic                 CLK,
    input  logic                 arstN,
    input  logic                 start,
    input  coreDefs::microOpT    op,
    input  coreDefs::dataT       srcA,
    input  coreDefs::dataT       srcB,
    input  coreDefs::robTagT     tag,
    output coreDefs::completionT result
);

    coreDefs::dataT shifted;
    coreDefs::dataT operandB;
    coreDefs::dataT aluOut;
    logic [63:0]    rotated;

    ////////////////////////////////////////
    // Barrel shifter on operand B
    ////////////////////////////////////////
    assign rotated = {srcB, srcB} >> op.shamt;

    always_comb begin
        case (op.shiftType)
            coreDefs::ShLsl: shifted = srcB << op.shamt;
            coreDefs::ShLsr: shifted = srcB >> op.shamt;
            coreDefs::ShAsr: shifted = $signed(srcB) >>> op.shamt;
            default:         shifted = rotated[31:0];
        endcase
    end

    // Immediate bypasses the shifter, zero-extended
    assign operandB = op.useImm ? {20'b0, op.imm} : shifted;

    always_comb begin
        case (op.opcode)
            coreDefs::OpAdd: aluOut = srcA + operandB;
            coreDefs::OpSub: aluOut = srcA - operandB;
            coreDefs::OpAnd: aluOut = srcA & operandB;
            coreDefs::OpOrr: aluOut = srcA | operandB;
            coreDefs::OpEor: aluOut = srcA ^ operandB;
            default:         aluOut = operandB;
        endcase
    end

    // Result stage, one op per cycle
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            result <= '0;
        end else begin
            result.valid <= start;
            result.tag   <= tag;
            result.value <= aluOut;
        end
    end

endmodule

//--- mulSequencer.sv
module mulSequencer (
    input  logic                 CLK,
    input  logic                 arstN,
    input  logic                 start,
    input  coreDefs::dataT       srcA,
    input  coreDefs::dataT       srcB,
    input  coreDefs::robTagT     tag,
    output logic                 busy,
    output coreDefs::completionT result
);

    typedef enum logic [1:0] {Idle, Run, Done} stateT;

    stateT            state;
    logic [4:0]       step;
    coreDefs::dataT   mcand;
    coreDefs::dataT   mplier;
    coreDefs::dataT   acc;
    coreDefs::robTagT tagQ;

    assign busy   = (state != Idle);
    assign result = '{valid: (state == Done), tag: tagQ, value: acc};

    ////////////////////////////////////////
    // Sequencer FSM
    ////////////////////////////////////////
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            state <= Idle;
            step  <= '0;
        end else begin
            case (state)
                Idle: if (start) begin
                    state <= Run;
                    step  <= '0;
                end
                Run: begin
                    step <= step + 1'b1;
                    if (step == 5'd31) state <= Done;
                end
                default: state <= Idle;
            endcase
        end
    end

    // Shift-add, one multiplier bit per step
    always_ff @(posedge CLK) begin
        if (state == Idle && start) begin
            mcand  <= srcA;
            mplier <= srcB;
            acc    <= '0;
            tagQ   <= tag;
        end else if (state == Run) begin
            if (mplier[0]) acc <= acc + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

//--- regFile.sv
module regFile (
    input  logic             CLK,
    input  logic             arstN,
    input  coreDefs::regIdxT raddrA,
    input  coreDefs::regIdxT raddrB,
    output coreDefs::dataT   rdataA,
    output coreDefs::dataT   rdataB,
    input  coreDefs::commitT commit
);

    coreDefs::dataT regs [16];

    // Asynchronous read ports
    assign rdataA = regs[raddrA];
    assign rdataB = regs[raddrB];

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (commit.valid) begin
            regs[commit.dest] <= commit.value;
        end
    end

endmodule

//--- outOfOrderCore.sv
module outOfOrderCore #(
    parameter int RobDepth = 4
) (
    input  logic              CLK,
    input  logic              arstN,
    input  logic              opValid,
    input  coreDefs::microOpT op,
    output logic              issueStall,
    output coreDefs::commitT  commit
);

    logic                 issue;
    logic                 robFull;
    logic                 mulBusy;
    logic                 aluStart;
    logic                 mulStart;
    coreDefs::robTagT     robTail;
    coreDefs::dataT       rdataA;
    coreDefs::dataT       rdataB;
    coreDefs::dataT       mulB;
    coreDefs::completionT aluResult;
    coreDefs::completionT mulResult;

    ////////////////////////////////////////
    // Unit steering and multiply operand
    ////////////////////////////////////////
    assign mulStart = issue && (op.opcode == coreDefs::OpMul);
    assign aluStart = issue && (op.opcode != coreDefs::OpMul);
    // No shift on the multiplier path
    assign mulB     = op.useImm ? {20'b0, op.imm} : rdataB;

    issueGate issueGate_i (
        .CLK (CLK), .arstN (arstN), .opValid (opValid), .op (op),
        .robFull (robFull), .mulBusy (mulBusy), .commit (commit),
        .issueStall (issueStall), .issue (issue)
    );

    reorderBuffer #(.RobDepth (RobDepth)) reorderBuffer_i (
        .CLK (CLK), .arstN (arstN), .issue (issue), .issueDest (op.dest),
        .aluDone (aluResult), .mulDone (mulResult), .tail (robTail),
        .full (robFull), .commit (commit)
    );

    aluPipe aluPipe_i (
        .CLK (CLK), .arstN (arstN), .start (aluStart), .op (op),
        .srcA (rdataA), .srcB (rdataB), .tag (robTail), .result (aluResult)
    );

    mulSequencer mulSequencer_i (
        .CLK (CLK), .arstN (arstN), .start (mulStart), .srcA (rdataA),
        .srcB (mulB), .tag (robTail), .busy (mulBusy), .result (mulResult)
    );

    regFile regFile_i (
        .CLK (CLK), .arstN (arstN), .raddrA (op.srcA), .raddrB (op.srcB),
        .rdataA (rdataA), .rdataB (rdataB), .commit (commit)
    );

endmodule

//--- tbClock.sv
module tbClock (
    output logic CLK,
    output logic arstN
);
    timeunit 1ns;
    timeprecision 100ps;

    // 100 ns period
    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    initial begin
        arstN = 1'b0;
        repeat (5) @(posedge CLK);
        #1 arstN = 1'b1;
    end

endmodule

//--- core_properties.sv
module core_properties (
    input logic                 CLK,
    input logic                 arstN,
    input logic                 issueStall,
    input logic                 robFull,
    input logic                 mulStart,
    input coreDefs::commitT     commit,
    input coreDefs::completionT mulResult
);
    timeunit 1ns;
    timeprecision 100ps;

    // Commit port stays quiet in reset
    commitIdleInReset: assert property (@(posedge CLK) !arstN |-> !commit.valid)
        else $error("commit.valid high while reset is asserted");

    fullStalls: assert property (@(posedge CLK) disable iff (!arstN) robFull |-> issueStall)
        else $error("reorder buffer full but issueStall low");

    // Sequencer needs 32 steps, never done right after start
    mulNotImmediate: assert property (
        @(posedge CLK) disable iff (!arstN) mulStart |=> !mulResult.valid
    ) else $error("multiplier completion in the cycle after its start");

endmodule

bind outOfOrderCore core_properties core_properties_i (
    .CLK        (CLK),
    .arstN      (arstN),
    .issueStall (issueStall),
    .robFull    (robFull),
    .mulStart   (mulStart),
    .commit     (commit),
    .mulResult  (mulResult)
);

//--- coreTb.sv
module coreTb;
    timeunit 1ns;
    timeprecision 100ps;

    // 300 ops at up to 34 cycles each, plus margin
    localparam int MaxCycles = 15000;
    localparam logic [31:0] Seed = 32'h433d_077c;

    logic              CLK;
    logic              arstN;
    logic              opValid;
    logic              issueStall;
    logic              started;
    coreDefs::microOpT op;
    coreDefs::commitT  commit;
    coreDefs::commitT  expQ [$];
    coreDefs::dataT    model [16];
    int                cycles = 0;

    tbClock tbClock_i (.CLK (CLK), .arstN (arstN));

    outOfOrderCore #(.RobDepth (4)) outOfOrderCore_i (
        .CLK (CLK), .arstN (arstN), .opValid (opValid), .op (op),
        .issueStall (issueStall), .commit (commit)
    );

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic coreDefs::dataT shiftOperand(
        coreDefs::dataT v, coreDefs::shiftT kind, logic [4:0] n
    );
        case (kind)
            coreDefs::ShLsl: return v << n;
            coreDefs::ShLsr: return v >> n;
            coreDefs::ShAsr: return coreDefs::dataT'($signed(v) >>> n);
            default:         return (n == 5'd0) ? v : ((v >> n) | (v << (6'd32 - n)));
        endcase
    endfunction

    function automatic coreDefs::dataT expectResult(coreDefs::microOpT o);
        coreDefs::dataT a;
        coreDefs::dataT b;
        a = model[o.srcA];
        if (o.useImm) b = {20'b0, o.imm};
        else if (o.opcode == coreDefs::OpMul) b = model[o.srcB];
        else b = shiftOperand(model[o.srcB], o.shiftType, o.shamt);
        case (o.opcode)
            coreDefs::OpAdd: return a + b;
            coreDefs::OpSub: return a - b;
            coreDefs::OpAnd: return a & b;
            coreDefs::OpOrr: return a | b;
            coreDefs::OpEor: return a ^ b;
            coreDefs::OpMul: return a * b;
            default:         return b;
        endcase
    endfunction

    function automatic coreDefs::microOpT makeOp(
        coreDefs::opcodeT opc, coreDefs::regIdxT d, coreDefs::regIdxT a, coreDefs::regIdxT b,
        logic useImm, logic [11:0] imm, coreDefs::shiftT st, logic [4:0] sh
    );
        return '{opc, d, a, b, useImm, imm, st, sh};
    endfunction

    function automatic coreDefs::microOpT randomOp();
        coreDefs::microOpT o;
        if ($urandom % 8 == 0) o.opcode = coreDefs::OpMul;
        else o.opcode = coreDefs::opcodeT'($urandom % 6);
        o.dest      = coreDefs::regIdxT'($urandom);
        o.srcA      = coreDefs::regIdxT'($urandom);
        o.srcB      = coreDefs::regIdxT'($urandom);
        o.useImm    = 1'($urandom);
        o.imm       = 12'($urandom);
        o.shiftType = coreDefs::shiftT'($urandom % 4);
        o.shamt     = 5'($urandom);
        return o;
    endfunction

    // Hold op until taken, predict at the take
    task automatic sendOp(input coreDefs::microOpT o, output int stalls);
        coreDefs::commitT expected;
        stalls  = 0;
        started = 1'b1;
        op      = o;
        opValid = 1'b1;
        @(negedge CLK);
        while (issueStall) begin
            stalls++;
            @(negedge CLK);
        end
        expected = '{valid: 1'b1, dest: o.dest, value: expectResult(o)};
        model[o.dest] = expected.value;
        expQ.push_back(expected);
        @(posedge CLK);
        #1;
        opValid = 1'b0;
    endtask

    task automatic drainCommits();
        while (expQ.size() != 0) @(negedge CLK);
        @(posedge CLK);
        #1;
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    always @(negedge CLK) begin
        if (arstN && !started) begin
            assert (!commit.valid && !issueStall)
                else abortRun("Commit or stall active before the first op was driven");
        end
        if (commit.valid) begin
            assert (expQ.size() != 0) else abortRun("Commit seen with no op outstanding");
            assert (commit.dest == expQ[0].dest && commit.value == expQ[0].value)
                else abortRun($sformatf("Mismatch at %0t ns: commit r%0d=%h, expected r%0d=%h",
                    $time, commit.dest, commit.value, expQ[0].dest, expQ[0].value));
            void'(expQ.pop_front());
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= MaxCycles) begin
            abortRun($sformatf("Timeout: run did not finish within %0d cycles", MaxCycles));
        end
    end

    initial begin
        int stalls;
        void'($urandom(Seed));
        opValid = 1'b0;
        op      = '0;
        started = 1'b0;
        for (int r = 0; r < 16; r++) model[r] = '0;
        @(posedge arstN);
        repeat (3) @(posedge CLK);
        #1;

        for (int r = 0; r < 16; r++) begin
            sendOp(makeOp(coreDefs::OpMov, coreDefs::regIdxT'(r), 4'd0, 4'd0, 1'b1,
                12'($urandom), coreDefs::ShLsl, 5'd0), stalls);
        end
        for (int i = 0; i < 240; i++) sendOp(randomOp(), stalls);
        drainCommits();

        // Multiply ahead of three ALU ops fills the ROB
        sendOp(makeOp(coreDefs::OpMul, 4'd1, 4'd2, 4'd3, 1'b0, 12'd0,
            coreDefs::ShLsl, 5'd0), stalls);
        sendOp(makeOp(coreDefs::OpAdd, 4'd4, 4'd5, 4'd6, 1'b0, 12'd0,
            coreDefs::ShLsl, 5'd3), stalls);
        sendOp(makeOp(coreDefs::OpEor, 4'd7, 4'd8, 4'd0, 1'b1, 12'h5a5,
            coreDefs::ShLsl, 5'd0), stalls);
        sendOp(makeOp(coreDefs::OpOrr, 4'd9, 4'd10, 4'd11, 1'b0, 12'd0,
            coreDefs::ShRor, 5'd7), stalls);
        sendOp(makeOp(coreDefs::OpSub, 4'd12, 4'd13, 4'd14, 1'b0, 12'd0,
            coreDefs::ShAsr, 5'd2), stalls);
        assert (stalls >= 30) else abortRun("Fifth op entered a full reorder buffer");
        drainCommits();

        // Register and multiplier hazards
        sendOp(makeOp(coreDefs::OpMul, 4'd1, 4'd1, 4'd2, 1'b0, 12'd0,
            coreDefs::ShLsl, 5'd4), stalls);
        sendOp(makeOp(coreDefs::OpAdd, 4'd3, 4'd1, 4'd4, 1'b0, 12'd0,
            coreDefs::ShLsr, 5'd1), stalls);
        assert (stalls >= 30) else abortRun("Op read a register with a pending result");
        sendOp(makeOp(coreDefs::OpMul, 4'd5, 4'd6, 4'd0, 1'b1, 12'h7ff,
            coreDefs::ShLsl, 5'd0), stalls);
        sendOp(makeOp(coreDefs::OpMul, 4'd7, 4'd8, 4'd9, 1'b0, 12'd0,
            coreDefs::ShLsl, 5'd0), stalls);
        assert (stalls >= 30) else abortRun("Second multiply started while the first ran");
        sendOp(makeOp(coreDefs::OpMov, 4'd7, 4'd0, 4'd0, 1'b1, 12'h123,
            coreDefs::ShLsl, 5'd0), stalls);
        assert (stalls >= 30) else abortRun("Op overwrote a register with a pending result");
        drainCommits();

        repeat (2) @(negedge CLK);
        if (expQ.size() == 0 && !issueStall) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abortRun("Ops still outstanding at the end of the run");
        end
    end

endmodule

//--- compile.f
coreDefs.sv
issueGate.sv
robPointers.sv
reorderBuffer.sv
aluPipe.sv
mulSequencer.sv
regFile.sv
outOfOrderCore.sv
tbClock.sv
core_properties.sv
coreTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --assert --timing -Wno-fatal
TOP      = coreTb
FILELIST = compile.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
